/* source/sd_probe_pkg.sv */
/*
 * shared types and constants for the sd probe
 * byte type, cmd0 frame, idle fill byte
 * probe result struct, ascii report characters
 */

package sd_probe_pkg;

    // ==============================
    // spi side
    // ==============================

    // one spi or ascii byte
    typedef logic [7:0] byte_t;

    // mosi fill and "no response yet" marker
    localparam byte_t idle_byte = 8'hFF;

    // cmd0 with its fixed crc, sent msb first
    localparam byte_t cmd0_frame [0:5] = '{8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95};

    // ==============================
    // result and report side
    // ==============================

    // 9 bits, timed_out on top
    typedef struct packed {
        logic  timed_out;
        byte_t response;
    } probe_result_t;

    // report line tags
    localparam byte_t char_resp_tag    = 8'h52;
    localparam byte_t char_timeout_tag = 8'h54;
    localparam byte_t char_newline     = 8'h0A;

endpackage

/* source/spi_byte_if.sv */
/*
 * byte level link between the cmd0 sequencer and the spi engine
 * valid/ready transmit, one-cycle receive pulse, chip select request
 */

`timescale 1ns/1ps

interface spi_byte_if;

    // transmit side, accepted on tx_valid && tx_ready
    sd_probe_pkg::byte_t tx_byte;
    logic                tx_valid;
    logic                tx_ready;

    // byte shifted in from miso, valid for one cycle
    sd_probe_pkg::byte_t rx_byte;
    logic                rx_valid;

    // chip select request, only changed while the engine is idle
    logic                cs_assert;

    modport sequencer (output tx_byte, tx_valid, cs_assert,
                       input  tx_ready, rx_byte, rx_valid);

    modport engine    (input  tx_byte, tx_valid, cs_assert,
                       output tx_ready, rx_byte, rx_valid);

endinterface

/* source/spi_byte_engine.sv */
/*
 * spi mode 0 byte engine, msb first, full duplex
 * sclk from a half-period divider, one byte per accepted tx_byte
 */

`timescale 1ns/1ps

module spi_byte_engine #(
    parameter int sclk_half_div = 4
) (
    input  logic             CLOCK_50,
    input  logic             KEY0,
    spi_byte_if.engine       bus,
    input  logic             spi_miso,
    output logic             spi_sclk,
    output logic             spi_mosi,
    output logic             spi_ss_n
);

    localparam int div_w = $clog2(sclk_half_div);

    // ==============================
    // state
    // ==============================
    logic [div_w-1:0]    div_cnt;
    // 16 half periods per byte
    logic [3:0]          half_cnt;
    logic                busy;
    logic                sclk_r;
    logic                mosi_r;
    logic                ss_n_r;
    logic                rx_valid_r;
    // tx bits leave the top, rx bits enter the bottom
    sd_probe_pkg::byte_t shreg;
    logic                half_end;

    assign half_end = (div_cnt == div_w'(sclk_half_div - 1));

    // ready again in the same cycle as rx_valid
    assign bus.tx_ready = ~busy;
    assign bus.rx_valid = rx_valid_r;
    assign bus.rx_byte  = shreg;

    assign spi_sclk = sclk_r;
    assign spi_mosi = mosi_r;
    assign spi_ss_n = ss_n_r;

    // ==============================
    // divider and bit timing
    // ==============================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy       <= 1'b0;
            div_cnt    <= '0;
            half_cnt   <= 4'd0;
            sclk_r     <= 1'b0;
            mosi_r     <= 1'b1;
            ss_n_r     <= 1'b1;
            rx_valid_r <= 1'b0;
        end else begin
            rx_valid_r <= 1'b0;
            // chip select follows the request one cycle late
            ss_n_r     <= ~bus.cs_assert;
            if (!busy) begin
                if (bus.tx_valid) begin
                    busy     <= 1'b1;
                    div_cnt  <= '0;
                    half_cnt <= 4'd0;
                    // first bit set up before the first rising edge
                    mosi_r   <= bus.tx_byte[7];
                end
            end else if (half_end) begin
                div_cnt  <= '0;
                half_cnt <= half_cnt + 4'd1;
                sclk_r   <= ~sclk_r;
                if (sclk_r && half_cnt == 4'd15) begin
                    // last falling edge, byte complete
                    busy       <= 1'b0;
                    mosi_r     <= 1'b1;
                    rx_valid_r <= 1'b1;
                end else if (sclk_r) begin
                    // falling edge, next bit out
                    mosi_r <= shreg[7];
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // load on accept, sample miso on each rising edge
    always_ff @(posedge CLOCK_50) begin
        if (!busy && bus.tx_valid) begin
            shreg <= bus.tx_byte;
        end else if (busy && half_end && !sclk_r) begin
            shreg <= {shreg[6:0], spi_miso};
        end
    end

endmodule

/* source/sd_cmd0_sequencer.sv */
/*
 * sd power-up and cmd0 sequencer
 * fill bytes with cs released, cmd0 frame, response polling
 * hands the probe result to the reporter
 */

`timescale 1ns/1ps

module sd_cmd0_sequencer #(
    parameter int power_up_bytes = 10,
    parameter int poll_limit     = 8
) (
    input  logic                        CLOCK_50,
    input  logic                        KEY0,
    spi_byte_if.sequencer               bus,
    output sd_probe_pkg::probe_result_t result,
    output logic                        result_valid,
    input  logic                        result_ready,
    output logic                        ledr0
);

    // counter must cover the longest phase, cmd0 is six bytes
    localparam int cnt_max_a = (power_up_bytes > poll_limit) ? power_up_bytes : poll_limit;
    localparam int cnt_max   = (cnt_max_a > 6) ? cnt_max_a : 6;
    localparam int cnt_w     = $clog2(cnt_max);

    typedef enum logic [2:0] {
        st_fill,
        st_cmd,
        st_poll,
        st_release,
        st_report,
        st_done
    } state_t;

    // ==============================
    // state
    // ==============================
    state_t                      state;
    logic [cnt_w-1:0]            cnt;
    logic                        tx_valid_r;
    // byte accepted, rx_valid not seen yet
    logic                        waiting;
    logic                        cs_r;
    logic                        result_valid_r;
    logic                        led_r;
    sd_probe_pkg::probe_result_t result_r;
    logic                        byte_done;
    logic                        issue;

    assign byte_done = waiting && bus.rx_valid;
    // one byte in flight at a time
    assign issue = !tx_valid_r && !waiting &&
                   (state == st_fill || state == st_cmd || state == st_poll);

    assign bus.tx_valid  = tx_valid_r;
    assign bus.cs_assert = cs_r;
    assign bus.tx_byte   = (state == st_cmd) ? sd_probe_pkg::cmd0_frame[cnt[2:0]]
                                             : sd_probe_pkg::idle_byte;

    assign result       = result_r;
    assign result_valid = result_valid_r;
    assign ledr0        = led_r;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state          <= st_fill;
            cnt            <= '0;
            tx_valid_r     <= 1'b0;
            waiting        <= 1'b0;
            cs_r           <= 1'b0;
            result_valid_r <= 1'b0;
            led_r          <= 1'b0;
        end else begin
            if (issue) begin
                tx_valid_r <= 1'b1;
            end else if (tx_valid_r && bus.tx_ready) begin
                tx_valid_r <= 1'b0;
                waiting    <= 1'b1;
            end
            if (byte_done) begin
                waiting <= 1'b0;
            end

            case (state)
                // power-up clocks, cs high
                st_fill: if (byte_done) begin
                    if (cnt == cnt_w'(power_up_bytes - 1)) begin
                        cnt   <= '0;
                        cs_r  <= 1'b1;
                        state <= st_cmd;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // replies during the frame are ignored
                st_cmd: if (byte_done) begin
                    if (cnt == cnt_w'(5)) begin
                        cnt   <= '0;
                        state <= st_poll;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_poll: if (byte_done) begin
                    if (bus.rx_byte != sd_probe_pkg::idle_byte) begin
                        led_r <= 1'b1;
                        cs_r  <= 1'b0;
                        state <= st_release;
                    end else if (cnt == cnt_w'(poll_limit - 1)) begin
                        cs_r  <= 1'b0;
                        state <= st_release;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                // let spi_ss_n go high before the result shows up
                st_release: state <= st_report;
                st_report: begin
                    if (!result_valid_r) begin
                        result_valid_r <= 1'b1;
                    end else if (result_ready) begin
                        result_valid_r <= 1'b0;
                        state          <= st_done;
                    end
                end
                default: state <= st_done;
            endcase
        end
    end

    // last polled byte wins, all-0xFF means timeout
    always_ff @(posedge CLOCK_50) begin
        if (state == st_poll && byte_done) begin
            result_r.response  <= bus.rx_byte;
            result_r.timed_out <= (bus.rx_byte == sd_probe_pkg::idle_byte);
        end
    end

endmodule

/* source/result_reporter.sv */
/*
 * probe result to ascii characters
 * "R" + two hex digits + newline, or "T" + newline
 */

`timescale 1ns/1ps

module result_reporter (
    input  logic                        CLOCK_50,
    input  logic                        KEY0,
    input  sd_probe_pkg::probe_result_t result,
    input  logic                        result_valid,
    output logic                        result_ready,
    output sd_probe_pkg::byte_t         char_data,
    output logic                        char_valid,
    input  logic                        char_ready
);

    sd_probe_pkg::probe_result_t held;
    logic [1:0]                  idx;
    logic [1:0]                  last_idx;
    logic                        char_valid_r;
    logic                        accept;

    // uppercase hex digit
    function automatic sd_probe_pkg::byte_t hex_char(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};
    endfunction

    // busy for the whole line
    assign result_ready = ~char_valid_r;
    assign accept       = result_valid && ~char_valid_r;
    assign last_idx     = held.timed_out ? 2'd1 : 2'd3;
    assign char_valid   = char_valid_r;

    // only idx and held feed this, so it holds under back-pressure
    always_comb begin
        case (idx)
            2'd0:    char_data = held.timed_out ? sd_probe_pkg::char_timeout_tag
                                                : sd_probe_pkg::char_resp_tag;
            2'd1:    char_data = held.timed_out ? sd_probe_pkg::char_newline
                                                : hex_char(held.response[7:4]);
            2'd2:    char_data = hex_char(held.response[3:0]);
            default: char_data = sd_probe_pkg::char_newline;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            idx          <= 2'd0;
            char_valid_r <= 1'b0;
        end else if (accept) begin
            idx          <= 2'd0;
            char_valid_r <= 1'b1;
        end else if (char_valid_r && char_ready) begin
            if (idx == last_idx) begin
                char_valid_r <= 1'b0;
            end else begin
                idx <= idx + 2'd1;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            held <= result;
        end
    end

endmodule

/* source/sd_probe_top.sv */
/*
 * sd card presence probe, pin level top
 * spi byte engine, cmd0 sequencer, ascii result reporter
 */

`timescale 1ns/1ps

module sd_probe_top #(
    parameter int sclk_half_div  = 4,
    parameter int power_up_bytes = 10,
    parameter int poll_limit     = 8
) (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       spi_miso,
    output logic       spi_sclk,
    output logic       spi_mosi,
    output logic       spi_ss_n,
    output logic       ledr0,
    output logic [7:0] char_data,
    output logic       char_valid,
    input  logic       char_ready
);

    // ==============================
    // internal links
    // ==============================
    spi_byte_if                  spi_bus ();
    sd_probe_pkg::probe_result_t result;
    logic                        result_valid;
    logic                        result_ready;

    // pins
    spi_byte_engine #(
        .sclk_half_div (sclk_half_div)
    ) u_engine (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (spi_bus.engine),
        .spi_miso (spi_miso),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_ss_n (spi_ss_n)
    );

    sd_cmd0_sequencer #(
        .power_up_bytes (power_up_bytes),
        .poll_limit     (poll_limit)
    ) u_sequencer (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .bus          (spi_bus.sequencer),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .ledr0        (ledr0)
    );

    // char stream out
    result_reporter u_reporter (
        .CLOCK_50     (CLOCK_50),
        .KEY0         (KEY0),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .char_data    (char_data),
        .char_valid   (char_valid),
        .char_ready   (char_ready)
    );

endmodule

/* tests/sd_card_model.sv */
/*
 * behavioral spi sd card for the probe testbench
 * counts fill bytes, captures the cmd0 frame
 * answers idle bytes, then one response byte
 */

`timescale 1ns/1ps

module sd_card_model (
    input  logic        rst_n,
    input  logic        spi_sclk,
    input  logic        spi_mosi,
    input  logic        spi_ss_n,
    output logic        spi_miso,
    input  logic [7:0]  idle_count,
    input  logic [7:0]  response,
    output int          fill_bytes,
    output int          fill_not_idle,
    output int          sel_bytes,
    output int          sclk_edges,
    output logic [47:0] cmd_bytes
);

    logic [7:0] rx_shift;
    logic [7:0] rx_next;
    // reply bits leave the top
    logic [7:0] tx_shift;
    int         bit_cnt;
    int         idle_left;
    logic       answered;

    assign spi_miso = tx_shift[7];

    always @(posedge spi_sclk or negedge spi_sclk or negedge rst_n) begin
        if (!rst_n) begin
            rx_shift      = 8'h00;
            tx_shift      = 8'hFF;
            bit_cnt       = 0;
            idle_left     = int'(idle_count);
            answered      = 1'b0;
            fill_bytes    = 0;
            fill_not_idle = 0;
            sel_bytes     = 0;
            sclk_edges    = 0;
            cmd_bytes     = 48'h0;
        end else if (spi_sclk) begin
            // rising edge, mosi sampled here
            sclk_edges = sclk_edges + 1;
            rx_next    = {rx_shift[6:0], spi_mosi};
            rx_shift   = rx_next;
            bit_cnt    = bit_cnt + 1;
            if (bit_cnt == 8) begin
                bit_cnt = 0;
                if (spi_ss_n) begin
                    // power-up clocks, card not selected
                    fill_bytes = fill_bytes + 1;
                    if (rx_next != 8'hFF) begin
                        fill_not_idle = fill_not_idle + 1;
                    end
                end else begin
                    // first six selected bytes are the command
                    if (sel_bytes < 6) begin
                        cmd_bytes = {cmd_bytes[39:0], rx_next};
                    end
                    sel_bytes = sel_bytes + 1;
                end
            end
        end else begin
            // falling edge, miso changes here
            sclk_edges = sclk_edges + 1;
            if (bit_cnt == 0) begin
                // byte boundary, pick the next reply byte
                if (sel_bytes >= 6 && !answered) begin
                    if (idle_left > 0) begin
                        tx_shift  = 8'hFF;
                        idle_left = idle_left - 1;
                    end else begin
                        tx_shift = response;
                        answered = 1'b1;
                    end
                end else begin
                    tx_shift = 8'hFF;
                end
            end else begin
                tx_shift = {tx_shift[6:0], 1'b1};
            end
        end
    end

endmodule

/* tests/sd_probe_tb.sv */
/*
 * sd probe testbench, scenarios from the golden file
 * random char_ready back-pressure on the report stream
 * checks fill bytes, cmd0 frame, characters, led and end state
 */

`timescale 1ns/1ps

module sd_probe_tb;

    localparam int fill_expected = 10;
    localparam int poll_expected = 8;
    localparam int char_wait_max = 4000;
    localparam int quiet_cycles  = 200;
    localparam int line_words    = 7;

    logic        CLOCK_50;
    logic        KEY0;
    logic        spi_miso;
    logic        spi_sclk;
    logic        spi_mosi;
    logic        spi_ss_n;
    logic        ledr0;
    logic [7:0]  char_data;
    logic        char_valid;
    logic        char_ready;
    // card model setup and counters
    logic [7:0]  idle_cfg;
    logic [7:0]  response_cfg;
    int          fill_bytes;
    int          fill_not_idle;
    int          sel_bytes;
    int          sclk_edges;
    logic [47:0] cmd_bytes;
    logic [7:0]  golden [0:63];
    logic [7:0]  cmd0_copy [0:5];
    logic [7:0]  exp_chars [0:3];
    integer      seed;

    sd_probe_top uut (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .spi_miso   (spi_miso),
        .spi_sclk   (spi_sclk),
        .spi_mosi   (spi_mosi),
        .spi_ss_n   (spi_ss_n),
        .ledr0      (ledr0),
        .char_data  (char_data),
        .char_valid (char_valid),
        .char_ready (char_ready)
    );

    sd_card_model card (
        .rst_n         (KEY0),
        .spi_sclk      (spi_sclk),
        .spi_mosi      (spi_mosi),
        .spi_ss_n      (spi_ss_n),
        .spi_miso      (spi_miso),
        .idle_count    (idle_cfg),
        .response      (response_cfg),
        .fill_bytes    (fill_bytes),
        .fill_not_idle (fill_not_idle),
        .sel_bytes     (sel_bytes),
        .sclk_edges    (sclk_edges),
        .cmd_bytes     (cmd_bytes)
    );

    // 8 ns clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    // ==============================
    // helpers
    // ==============================
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopped on the first mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // card config must be stable before KEY0 falls
    task automatic apply_reset();
        KEY0 = 1'b0;
        repeat (10) @(posedge CLOCK_50);
        #1;
        // pin levels while held in reset
        check_value("spi_ss_n", 32'(spi_ss_n), 32'd1);
        check_value("spi_mosi", 32'(spi_mosi), 32'd1);
        check_value("spi_sclk", 32'(spi_sclk), 32'd0);
        check_value("char_valid", 32'(char_valid), 32'd0);
        check_value("ledr0", 32'(ledr0), 32'd0);
        KEY0 = 1'b1;
    endtask

    // ready driven after the rising edge, stream sampled on the falling edge
    task automatic collect_chars(input int count);
        int         got;
        int         idle_cycles;
        int         rnd;
        logic       stalled;
        logic [7:0] held;
        got         = 0;
        idle_cycles = 0;
        stalled     = 1'b0;
        held        = 8'h00;
        while (got < count) begin
            @(posedge CLOCK_50);
            #1;
            rnd        = $random(seed);
            char_ready = rnd[0];
            @(negedge CLOCK_50);
            // stalled character must hold
            if (stalled) begin
                check_value("char_valid", 32'(char_valid), 32'd1);
                check_value("char_data", 32'(char_data), 32'(held));
            end
            if (char_valid && char_ready) begin
                check_value("char_data", 32'(char_data), 32'(exp_chars[got]));
                got         = got + 1;
                idle_cycles = 0;
                stalled     = 1'b0;
            end else begin
                stalled     = char_valid;
                held        = char_data;
                idle_cycles = idle_cycles + 1;
                if (idle_cycles > char_wait_max) begin
                    abort_run("timed out waiting for the next report character");
                end
            end
        end
        @(posedge CLOCK_50);
        #1;
        char_ready = 1'b0;
    endtask

    // bus and stream stay silent once the line is out
    task automatic check_quiet_end();
        int edges_then;
        edges_then = sclk_edges;
        repeat (quiet_cycles) begin
            @(negedge CLOCK_50);
            check_value("char_valid", 32'(char_valid), 32'd0);
            check_value("spi_ss_n", 32'(spi_ss_n), 32'd1);
        end
        check_value("sclk_edges", 32'(sclk_edges), 32'(edges_then));
        @(posedge CLOCK_50);
        #1;
    endtask

    // ==============================
    // scenario loop
    // ==============================
    initial begin
        int scenarios;
        int base;
        int n_idle;
        int count;
        int polls;
        seed         = 32'h167cf8c4;
        KEY0         = 1'b1;
        char_ready   = 1'b0;
        idle_cfg     = 8'h00;
        response_cfg = 8'h00;
        cmd0_copy    = '{8'h40, 8'h00, 8'h00, 8'h00, 8'h00, 8'h95};
        $readmemh("tests/probe_golden.txt", golden);
        scenarios = int'(golden[0]);
        if (scenarios < 1 || scenarios > 9) begin
            abort_run("golden file is missing or has a bad scenario count");
        end
        #1;
        for (int s = 0; s < scenarios; s++) begin
            base         = 1 + s * line_words;
            n_idle       = int'(golden[base]);
            response_cfg = golden[base + 1];
            count        = int'(golden[base + 2]);
            idle_cfg     = golden[base];
            if (count < 1 || count > 4) begin
                abort_run("golden line has a bad character count");
            end
            for (int i = 0; i < 4; i++) begin
                exp_chars[i] = golden[base + 3 + i];
            end
            apply_reset();
            collect_chars(count);
            // response read only if it came within the poll limit
            polls = (n_idle < poll_expected) ? n_idle + 1 : poll_expected;
            check_value("spi_ss_n", 32'(spi_ss_n), 32'd1);
            check_value("ledr0", 32'(ledr0), 32'(n_idle < poll_expected));
            check_value("fill_bytes", 32'(fill_bytes), 32'(fill_expected));
            check_value("fill_not_idle", 32'(fill_not_idle), 32'd0);
            check_value("sel_bytes", 32'(sel_bytes), 32'(6 + polls));
            for (int i = 0; i < 6; i++) begin
                check_value($sformatf("cmd_byte%0d", i), 32'(cmd_bytes[47 - 8 * i -: 8]),
                            32'(cmd0_copy[i]));
            end
            check_quiet_end();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

/* tests/probe_golden.txt */
// first word: scenario count, then one scenario per line
// idle bytes N, response, char count, four char bytes (unused ones 00)
08
00 01 04 52 30 31 0A
03 00 04 52 30 30 0A
07 05 04 52 30 35 0A
01 A5 04 52 41 35 0A
05 3F 04 52 33 46 0A
02 FE 04 52 46 45 0A
08 01 02 54 0A 00 00
0C C1 02 54 0A 00 00

/* build.f */
source/sd_probe_pkg.sv
source/spi_byte_if.sv
source/spi_byte_engine.sv
source/sd_cmd0_sequencer.sv
source/result_reporter.sv
source/sd_probe_top.sv
tests/sd_card_model.sv
tests/sd_probe_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the sd probe testbench with verilator
# the exit status is the simulator's, non-zero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module sd_probe_tb -f build.f -o sim_sd_probe
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_sd_probe
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
fi
exit $status
